//--- design/riscPkg.sv
`default_nettype none

package riscPkg;

  // ALU operation field of register-format instructions
  typedef enum logic [3:0] {
    opMov, opLsl, opAsr, opRor,
    opAnd, opAnn, opIor, opXor,
    opAdd, opSub, opMul, opDiv,
    opFad, opFsb, opFml, opFdv  // Floating point, executed as no-ops
  } opCode;

  // Branch conditions, inverted by the inv bit
  typedef enum logic [2:0] {
    ccMi, ccEq, ccCs, ccVs, ccLs, ccLt, ccLe, ccT
  } condCode;

  typedef union packed {
    struct packed {
      logic p, q, u, v;
      logic [3:0] ira;
      logic [3:0] irb;
      opCode op;
      logic [15:0] imm;  // irc sits in the low nibble
    } regFmt;
    struct packed {
      logic p, q, u, v;
      logic [3:0] ira;
      logic [3:0] irb;
      logic [19:0] off;  // Signed byte offset
    } memFmt;
    struct packed {
      logic p, q, u, v;
      logic inv;
      condCode cc;
      logic [1:0] spare;
      logic [21:0] disp;  // Signed word displacement
    } brFmt;
  } instrWord;

endpackage

`default_nettype wire

//--- design/busPkg.sv
`default_nettype none

package busPkg;

  // Word address width; byte addresses carry two more bits
  localparam int wordAddrBits = 22;

  // First fetch after reset, base of the boot ROM
  localparam logic [wordAddrBits-1:0] startAdr = 22'h3FF800;

  // Byte address of the output port
  localparam logic [wordAddrBits+1:0] ioPortAdr = 24'hFFFFC0;

endpackage

`default_nettype wire

//--- design/barrelShifter.sv
`timescale 1ns/10ps
`default_nettype none

module barrelShifter
  import riscPkg::*;
(
  input  logic [31:0] x,
  input  logic [4:0]  sc,
  input  opCode       op,
  output logic [31:0] y
);

  logic [31:0] xr;  // x bit-reversed, LSL runs as a right shift
  logic [31:0] s;
  logic isLsl;
  logic fill;

  assign isLsl = (op == opLsl);
  assign fill  = (op == opAsr) & x[31];  // Sign fill for ASR only

  always_comb begin
    for (int i = 0; i < 32; i++)
      xr[i] = x[31 - i];
    s = isLsl ? xr : x;
    // Log stages 16, 8, 4, 2, 1
    for (int k = 4; k >= 0; k--) begin
      if (sc[k]) begin
        if (op == opRor)
          s = (s >> (1 << k)) | (s << (32 - (1 << k)));
        else
          s = (s >> (1 << k)) | ({32{fill}} & ~(32'hFFFF_FFFF >> (1 << k)));
      end
    end
    for (int i = 0; i < 32; i++)
      y[i] = isLsl ? s[31 - i] : s[i];  // Undo the reversal
  end

endmodule

`default_nettype wire

//--- design/mulDivUnit.sv
`timescale 1ns/10ps
`default_nettype none

module mulDivUnit (
  input  logic        clk,
  input  logic        rst,
  input  logic        runMul,
  input  logic        runDiv,
  input  logic        isSigned,
  input  logic [31:0] x,
  input  logic [31:0] y,
  output logic        stall,
  output logic [31:0] prodLo,
  output logic [31:0] prodHi,
  output logic [31:0] quot,
  output logic [31:0] rem
);

  logic [5:0] step;
  logic [31:0] hiReg, loReg, curHi, curLo, nextHi, nextLo;
  logic xNeg, yNeg, remZero;
  logic [31:0] xMag, yMag, quotSigned;
  logic [32:0] addSum, divShift, divDiff;

  assign stall = (runMul | runDiv) & (step != 6'd32);  // 32 steps, then done
  assign xNeg  = isSigned & x[31];
  assign yNeg  = isSigned & y[31];
  assign xMag  = xNeg ? -x : x;
  assign yMag  = yNeg ? -y : y;

  // Step 0 starts from the operands directly
  assign curHi = (step == 6'd0) ? 32'b0 : hiReg;
  assign curLo = (step == 6'd0) ? (runDiv ? xMag : x) : loReg;

  assign addSum   = {1'b0, curHi} + (curLo[0] ? {1'b0, y} : 33'b0);  // Shift-add
  assign divShift = {curHi, curLo[31]};                               // Restoring divide
  assign divDiff  = divShift - {1'b0, yMag};

  always_comb begin
    if (runDiv) begin
      nextHi = divDiff[32] ? divShift[31:0] : divDiff[31:0];
      nextLo = {curLo[30:0], ~divDiff[32]};
    end else begin
      nextHi = addSum[32:1];
      nextLo = {addSum[0], curLo[31:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      step <= 6'd0;
    else
      step <= stall ? step + 6'd1 : 6'd0;
  end

  always_ff @(posedge clk) begin
    if (stall) begin
      hiReg <= nextHi;
      loReg <= nextLo;
    end
  end

  // Unsigned product, high half corrected for signed operands
  assign prodLo = loReg;
  assign prodHi = hiReg - (xNeg ? y : 32'b0) - (yNeg ? x : 32'b0);

  // Floor quotient with non-negative remainder
  assign remZero    = (hiReg == 32'b0);
  assign quotSigned = (xNeg ^ yNeg) ? -loReg : loReg;
  assign quot = (xNeg & ~remZero) ? (yNeg ? quotSigned + 1'b1 : quotSigned - 1'b1) : quotSigned;
  assign rem  = (xNeg & ~remZero) ? yMag - hiReg : hiReg;

endmodule

`default_nettype wire

//--- design/riscCore.sv
`timescale 1ns/10ps
`default_nettype none

module riscCore
  import riscPkg::*, busPkg::*;
#(
  parameter int romAddrBits = 9
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    memwait,
  input  logic [31:0]             romData,
  input  logic [31:0]             inbus,
  output logic [romAddrBits-1:0]  romAdr,
  output logic [wordAddrBits+1:0] adr,
  output logic                    rd,
  output logic                    wr,
  output logic                    ben,
  output logic [31:0]             outbus
);

  instrWord ins;
  logic p, q, u, v;
  opCode op;
  logic [3:0] ira, ira0, irb, irc;
  logic [15:0] imm;
  logic [19:0] off;
  logic [wordAddrBits-1:0] disp;
  condCode cc;
  logic inv;

  logic [wordAddrBits-1:0] pc, pcmux, nxpc;
  logic [31:0] regs [16];
  logic n, z, c, ov;
  logic [31:0] h;  // Aux register for high product and remainder
  logic stall1;    // Second cycle of a load or store

  logic isAdd, isSub, isMul, isDiv, isFp;
  logic ldr, str, br;
  logic condRaw, cond;
  logic stall, stallL, mdStall;
  logic regwr;

  logic [31:0] a, b, c0, c1, aluRes, regmux;
  logic [31:0] shOut, prodLo, prodHi, quot, rem;
  logic resSign, bSign, cSign;
  logic [1:0] lane;
  logic [7:0] inbusL;
  logic [23:0] inbusH;

  barrelShifter shifter (
    .x (b),
    .sc(c1[4:0]),
    .op(op),
    .y (shOut)
  );

  mulDivUnit mulDiv (
    .clk     (clk),
    .rst     (rst),
    .runMul  (isMul),
    .runDiv  (isDiv),
    .isSigned(~u),
    .x       (b),
    .y       (c1),
    .stall   (mdStall),
    .prodLo  (prodLo),
    .prodHi  (prodHi),
    .quot    (quot),
    .rem     (rem)
  );

  // Instruction fields
  assign ins  = romData;
  assign p    = ins.regFmt.p;
  assign q    = ins.regFmt.q;
  assign u    = ins.regFmt.u;
  assign v    = ins.regFmt.v;
  assign ira  = ins.regFmt.ira;
  assign irb  = ins.regFmt.irb;
  assign op   = ins.regFmt.op;
  assign imm  = ins.regFmt.imm;
  assign irc  = ins.regFmt.imm[3:0];
  assign off  = ins.memFmt.off;
  assign disp = ins.brFmt.disp;
  assign cc   = ins.brFmt.cc;
  assign inv  = ins.brFmt.inv;

  assign isAdd = ~p & (op == opAdd);
  assign isSub = ~p & (op == opSub);
  assign isMul = ~p & (op == opMul);
  assign isDiv = ~p & (op == opDiv);
  assign isFp  = ~p & (op inside {opFad, opFsb, opFml, opFdv});
  assign ldr   = p & ~q & ~u;
  assign str   = p & ~q & u;
  assign br    = p & q;

  // Operands
  assign ira0 = br ? 4'd15 : ira;  // Link register on branch
  assign a    = regs[ira0];
  assign b    = regs[irb];
  assign c0   = regs[irc];
  assign c1   = q ? {{16{v}}, imm} : c0;

  always_comb begin
    case (op)
      opMov: begin
        if (q)
          aluRes = ~u ? {{16{v}}, imm} : {imm, 16'b0};
        else
          aluRes = ~u ? c0 : (~v ? h : {n, z, c, ov, 20'b0, 8'h50});
      end
      opLsl, opAsr, opRor: aluRes = shOut;
      opAnd: aluRes = b & c1;
      opAnn: aluRes = b & ~c1;
      opIor: aluRes = b | c1;
      opXor: aluRes = b ^ c1;
      opAdd: aluRes = b + c1 + 32'(u & c);  // u selects add with carry
      opSub: aluRes = b - c1 - 32'(u & c);
      opMul: aluRes = prodLo;
      opDiv: aluRes = quot;
      default: aluRes = '0;  // FP ops write nothing
    endcase
  end

  // Memory access
  assign adr    = b[wordAddrBits+1:0] + {{4{off[19]}}, off};
  assign rd     = ldr & ~stall1;
  assign wr     = str & ~stall1;
  assign ben    = p & ~q & v & ~stall1;
  assign lane   = adr[1:0];
  assign outbus = ben ? {4{a[7:0]}} : a;  // Memory picks the lane
  assign inbusL = ~ben ? inbus[7:0] : inbus[8*lane +: 8];
  assign inbusH = ~ben ? inbus[31:8] : 24'b0;  // Byte loads zero-extend

  assign regwr  = (~p & ~stall & ~isFp) | (ldr & ~stall1) | (br & cond & v);
  assign regmux = ldr ? {inbusH, inbusL} :
                  (br & v) ? {8'b0, nxpc, 2'b0} : aluRes;

  // Branch condition
  always_comb begin
    case (cc)
      ccMi: condRaw = n;
      ccEq: condRaw = z;
      ccCs: condRaw = c;
      ccVs: condRaw = ov;
      ccLs: condRaw = c | z;
      ccLt: condRaw = n ^ ov;
      ccLe: condRaw = (n ^ ov) | z;
      default: condRaw = 1'b1;  // Always
    endcase
  end
  assign cond = inv ^ condRaw;

  // Next PC, also the ROM address
  assign nxpc   = pc + 1'b1;
  assign pcmux  = rst ? startAdr :
                  stall ? pc :
                  (br & cond & u) ? nxpc + disp :
                  (br & cond & ~u) ? c0[wordAddrBits+1:2] : nxpc;
  assign romAdr = pcmux[romAddrBits-1:0];

  assign stallL = (ldr | str) & ~stall1;
  assign stall  = stallL | mdStall;

  assign resSign = aluRes[31];
  assign bSign   = b[31];
  assign cSign   = c1[31];

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= startAdr;
      stall1 <= 1'b0;
      n      <= 1'b0;
      z      <= 1'b0;
      c      <= 1'b0;
      ov     <= 1'b0;
    end else if (~memwait) begin  // Everything freezes in wait states
      pc     <= pcmux;
      stall1 <= stallL;
      if (regwr) begin
        regs[ira0] <= regmux;
        n <= regmux[31];
        z <= (regmux == 32'b0);
      end
      if (isAdd) begin
        c  <= (~bSign & cSign & ~resSign) | (bSign & cSign & resSign) | (bSign & ~resSign);
        ov <= (resSign & ~bSign & ~cSign) | (~resSign & bSign & cSign);
      end else if (isSub) begin
        c  <= (~bSign & cSign & ~resSign) | (bSign & cSign & resSign) | (~bSign & resSign);
        ov <= (resSign & ~bSign & cSign) | (~resSign & bSign & ~cSign);
      end
      if ((isMul | isDiv) & ~mdStall)
        h <= isMul ? prodHi : rem;
    end
  end

endmodule

`default_nettype wire

//--- design/bootRom.sv
`timescale 1ns/10ps
`default_nettype none

module bootRom #(
  parameter int romAddrBits = 9
) (
  input  logic                   clk,
  input  logic                   en,
  input  logic [romAddrBits-1:0] adr,
  output logic [31:0]            data
);

  logic [31:0] mem [2**romAddrBits];

  initial begin
    $readmemh("dv/program.hex", mem);
  end

  always_ff @(posedge clk) begin
    if (en)  // Held while the core waits on memory
      data <= mem[adr];
  end

endmodule

`default_nettype wire

//--- design/memorySystem.sv
`timescale 1ns/10ps
`default_nettype none

module memorySystem
  import busPkg::*;
#(
  parameter int ramAddrBits = 10,
  parameter int waitStates  = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [wordAddrBits+1:0] adr,
  input  logic                    rd,
  input  logic                    wr,
  input  logic                    ben,
  input  logic [31:0]             wdata,
  output logic [31:0]             rdata,
  output logic                    memwait,
  output logic                    ioValid,
  output logic [31:0]             ioData
);

  localparam int cntBits = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

  logic [31:0] ram [2**ramAddrBits];
  logic [cntBits-1:0] waitCnt;
  logic [ramAddrBits-1:0] wordIdx;
  logic [1:0] lane;
  logic ioHit;
  logic wrDone;

  assign wordIdx = adr[ramAddrBits+1:2];
  assign lane    = adr[1:0];
  assign ioHit   = (adr == ioPortAdr);

  // Strobe stays up through the wait states; last cycle completes the access
  assign memwait = (rd | wr) & (waitCnt != cntBits'(waitStates));
  assign wrDone  = wr & ~memwait;
  assign rdata   = ram[wordIdx];

  always_ff @(posedge clk) begin
    if (rst)
      waitCnt <= '0;
    else if (memwait)
      waitCnt <= waitCnt + 1'b1;
    else
      waitCnt <= '0;
  end

  always_ff @(posedge clk) begin
    if (wrDone & ~ioHit) begin
      if (ben)
        ram[wordIdx][8*lane +: 8] <= wdata[8*lane +: 8];
      else
        ram[wordIdx] <= wdata;
    end
  end

  // Output port
  always_ff @(posedge clk) begin
    if (rst)
      ioValid <= 1'b0;
    else
      ioValid <= wrDone & ioHit;  // One pulse per store
  end

  always_ff @(posedge clk) begin
    if (wrDone & ioHit)
      ioData <= wdata;
  end

endmodule

`default_nettype wire

//--- design/riscSystem.sv
`timescale 1ns/10ps
`default_nettype none

module riscSystem
  import busPkg::*;
#(
  parameter int romAddrBits = 9,
  parameter int ramAddrBits = 10,
  parameter int waitStates  = 2
) (
  input  logic        clk,
  input  logic        rst,
  output logic        ioValid,
  output logic [31:0] ioData
);

  logic [romAddrBits-1:0] romAdr;
  logic [31:0] romData;
  logic [wordAddrBits+1:0] adr;
  logic rd, wr, ben, memwait;
  logic [31:0] inbus, outbus;

  riscCore #(.romAddrBits(romAddrBits)) core (
    .clk(clk), .rst(rst), .memwait(memwait),
    .romData(romData), .inbus(inbus), .romAdr(romAdr),
    .adr(adr), .rd(rd), .wr(wr), .ben(ben), .outbus(outbus)
  );

  bootRom #(.romAddrBits(romAddrBits)) rom (
    .clk (clk),
    .en  (rst | ~memwait),  // Fetch freezes with the core
    .adr (romAdr),
    .data(romData)
  );

  memorySystem #(.ramAddrBits(ramAddrBits), .waitStates(waitStates)) mem (
    .clk(clk), .rst(rst), .adr(adr), .rd(rd), .wr(wr), .ben(ben),
    .wdata(outbus), .rdata(inbus), .memwait(memwait),
    .ioValid(ioValid), .ioData(ioData)
  );

endmodule

`default_nettype wire

//--- dv/tb_riscSystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_riscSystem;

  localparam int numWords    = 20;
  localparam int resetCycles = 10;
  localparam int waitStates  = 2;  // Same as the DUT default
  localparam int quietCycles = 4;  // No port write can finish this soon after reset

  // Reset, 28 loads and stores, one MUL and one DIV, about 50 single-cycle steps
  localparam int runCycles  = resetCycles + 28 * (2 + waitStates) + 2 * 33 + 50;
  localparam int cycleLimit = 10 * runCycles;

  // Words the boot program writes to the output port in order
  localparam logic [31:0] expectedWords [numWords] = '{
    32'h87654321,  // MOV high half then IOR low half
    32'h00000001,  // ADD with carry out
    32'h00000006,  // ADD with carry in gives 0 + 5 + 1
    32'hFFFFFFFB,  // SUB with borrow gives -1 - 3 - 1
    32'h00004300,  // AND
    32'h87654020,  // ANN
    32'h789ABCDE,  // XOR with all ones
    32'h76543210,  // LSL 4
    32'hFF876543,  // ASR 8
    32'h32187654,  // ROR 12
    32'hFFFFFFF1,  // Low word of -3 * 5
    32'hFFFFFFFF,  // High word from H
    32'hFFFFFFFC,  // -7 / 2 rounds down to -4
    32'h00000001,  // Remainder from H
    32'h87654321,  // Word store and load
    32'h21F1DE01,  // Four byte stores then one word load
    32'h000000F1,  // Byte load with upper bits zero
    32'h00000005,  // Countdown loop passes
    32'h00000007,  // Written after eight untaken branches
    32'h00FFE0F8   // Link value is the byte address of ROM word 62
  };

  logic clk;
  logic rst;
  logic ioValid;
  logic [31:0] ioData;

  int cycle = 0;
  int matched = 0;
  logic prevValid = 1'b0;

  riscSystem UUT (
    .clk    (clk),
    .rst    (rst),
    .ioValid(ioValid),
    .ioData (ioData)
  );

  always #10 clk = ~clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  // Outputs are read on the rising edge before the DUT updates them
  always @(posedge clk) begin
    cycle <= cycle + 1;
    prevValid <= ioValid;
    if (cycle >= cycleLimit)
      abortRun($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                         cycle, matched, numWords));
    if (cycle >= 1 && cycle < resetCycles + quietCycles)
      assert (ioValid == 1'b0)
      else abortRun("Output port became valid during reset or right after it");
    if (ioValid === 1'b1) begin
      assert (prevValid == 1'b0)
      else abortRun("Output valid stayed high for more than one cycle");
      assert (matched < numWords && ioData == expectedWords[matched])
        matched <= matched + 1;
      else
        abortRun($sformatf("FAILED @%0t: result %0d is %h, expected %h",
                           $time, matched, ioData, expectedWords[matched]));
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait (matched == numWords);
    repeat (20) @(negedge clk);  // An extra port write would fail the compare
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/program.hex
// One instruction word per line, starting at ROM word 0
// Bits 31:28 p q u v, 27:24 ira, 23:20 irb, 19:0 op and imm, offset or displacement
4E000000  // MOV  R14, 0
61008765  // MOV' R1, 8765 into high half
41164321  // IOR  R1, R1, 4321
A1EFFFC0  // STW  R1 to port
5200FFFF  // MOV  R2, -1
43280002  // ADD  R3, R2, 2
64E80005  // ADD' R4, R14, 5
A3EFFFC0  // STW  R3 to port
A4EFFFC0  // STW  R4 to port
45E90001  // SUB  R5, R14, 1
66290003  // SUB' R6, R2, 3
A6EFFFC0  // STW  R6 to port
4714FF00  // AND  R7, R1, FF00
A7EFFFC0  // STW  R7 to port
48150F0F  // ANN  R8, R1, 0F0F
A8EFFFC0  // STW  R8 to port
09170002  // XOR  R9, R1, R2
A9EFFFC0  // STW  R9 to port
43110004  // LSL  R3, R1, 4
A3EFFFC0  // STW  R3 to port
44120008  // ASR  R4, R1, 8
A4EFFFC0  // STW  R4 to port
4513000C  // ROR  R5, R1, 12
A5EFFFC0  // STW  R5 to port
5300FFFD  // MOV  R3, -3
443A0005  // MUL  R4, R3, 5
25000000  // MOV' R5, H
A4EFFFC0  // STW  R4 to port
A5EFFFC0  // STW  R5 to port
5600FFF9  // MOV  R6, -7
476B0002  // DIV  R7, R6, 2
28000000  // MOV' R8, H
A7EFFFC0  // STW  R7 to port
A8EFFFC0  // STW  R8 to port
A1E00040  // STW  R1, [R14 + 40]
82E00040  // LDW  R2, [R14 + 40]
A2EFFFC0  // STW  R2 to port
B8E00044  // STB  R8, lane 0
B9E00045  // STB  R9, lane 1
B4E00046  // STB  R4, lane 2
B1E00047  // STB  R1, lane 3
8AE00044  // LDW  R10, [R14 + 44]
AAEFFFC0  // STW  R10 to port
9BE00046  // LDB  R11, [R14 + 46]
ABEFFFC0  // STW  R11 to port
4C000005  // MOV  R12, 5
4D000000  // MOV  R13, 0
4DD80001  // ADD  R13, R13, 1
4CC90001  // SUB  R12, R12, 1
E93FFFFD  // BNE  back to word 47
ADEFFFC0  // STW  R13 to port
4CE80007  // ADD  R12, R14, 7 clears N Z C V
E0000008  // BMI  past word 60
E1000007  // BEQ
E2000006  // BCS
E3000005  // BVS
E4000004  // BLS
E5000003  // BLT
E6000002  // BLE
EF000001  // Never
ACEFFFC0  // STW  R12 to port
F7000001  // BL   to word 63
AEEFFFC0  // STW  R14, jumped over
AFEFFFC0  // STW  R15 to port
E73FFFFF  // B    to itself

//--- project.f
design/riscPkg.sv
design/busPkg.sv
design/barrelShifter.sv
design/mulDivUnit.sv
design/riscCore.sv
design/bootRom.sv
design/memorySystem.sv
design/riscSystem.sv
dv/tb_riscSystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_riscSystem -f project.f \
  && ./obj_dir/Vtb_riscSystem 2>&1 | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }

grep -qx "TEST OK" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed, see sim.log"; exit 1; }
